//--- src.f
common/msg_pkg.sv
common/pacer_pkg.sv
hw/msg_assembler.sv
pacer/zmw_bank.sv
pacer/pacer_fsm.sv
hw/status_reporter.sv
hw/app_top.sv
bench/app_tb.sv

//--- bench/app_tb.sv
`timescale 1ns/100ps
`default_nettype none

module app_tb;

  localparam int RESET_CYCLES = 10;
  localparam logic [31:0] LFSR_SEED = 32'd81919;
  localparam int ACK_TIMEOUT = 20;
  localparam int REPORT_TIMEOUT = 1000;  // longer than one frame period
  localparam int QUIET_CYCLES = 50;
  localparam int RUN_CLOCKS = 200;       // clocks per frame for the runs

  // state codes as they show up in reports and on the LEDs
  localparam logic [3:0] ST_STOPPED = 4'd1;
  localparam logic [3:0] ST_INIT = 4'd2;
  localparam logic [3:0] ST_FRAME = 4'd3;
  localparam logic [3:0] ST_INTERFRAME = 4'd4;

  logic CLK;
  logic RESET;
  logic pc_msg_valid;
  logic [31:0] pc_msg;
  logic pc_msg_ack;
  logic fpga_msg_valid;
  logic [31:0] fpga_msg;
  logic app_running;
  logic app_error;
  logic [3:0] gpio_led;

  logic [31:0] lfsr_state = LFSR_SEED;
  int cycle_cnt = 0;

  // reports seen by the monitor in arrival order
  logic [31:0] report_q[$];
  int report_cycle_q[$];
  logic report_running_q[$];
  int frame_entry_cycles[$];  // report stamps of each entry into FRAME

  app_top DUT (
    .CLK(CLK), .RESET(RESET),
    .pc_msg_valid(pc_msg_valid), .pc_msg(pc_msg), .pc_msg_ack(pc_msg_ack),
    .fpga_msg_valid(fpga_msg_valid), .fpga_msg(fpga_msg),
    .app_running(app_running), .app_error(app_error), .gpio_led(gpio_led)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // report monitor
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (fpga_msg_valid === 1'b1) begin
      report_q.push_back(fpga_msg);
      report_cycle_q.push_back(cycle_cnt);
      report_running_q.push_back(app_running);  // state is one cycle ahead of the report
    end
  end

  // 32 bit fibonacci with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | lfsr_state[0];
    end
  endtask

  function automatic logic [95:0] control_msg(input logic start, input logic [23:0] frames,
                                              input logic [23:0] clocks);
    logic [95:0] m;
    m = '0;
    m[0] = 1'b0;  // control type
    m[6] = start;
    m[31:8] = frames;
    m[55:32] = clocks;
    return m;
  endfunction

  // data type with the start bit set, which must still be ignored
  function automatic logic [95:0] data_msg();
    logic [95:0] m;
    m = '0;
    m[0] = 1'b1;
    m[6] = 1'b1;
    m[31:8] = 24'd5;
    m[55:32] = 24'd300;
    return m;
  endfunction

  function automatic logic [31:0] report_word(input logic [3:0] old_code,
                                              input logic [3:0] new_code,
                                              input logic [23:0] frames);
    return {frames, old_code, new_code};
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("Finished with errors");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("Finished with errors");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic step_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic send_word(input logic [31:0] word);
    int waited;
    waited = 0;
    pc_msg_valid = 1'b1;
    pc_msg = word;
    do begin
      @(posedge CLK);
      check_value(pc_msg_ack, pc_msg_valid, "pc_msg_ack equals pc_msg_valid");
      waited++;
    end while (!pc_msg_ack && waited < ACK_TIMEOUT);
    if (!pc_msg_ack) begin
      stop_on_timeout("pc_msg_ack");
    end
    #1;
    pc_msg_valid = 1'b0;
    pc_msg = '0;
  endtask

  task automatic idle_gap();
    int gap;
    random_bits(2, gap);  // 0 to 3 idle cycles
    for (int i = 0; i < gap; i++) begin
      @(posedge CLK);
      check_value(pc_msg_ack, pc_msg_valid, "pc_msg_ack low while idle");
      #1;
    end
  endtask

  // low word goes first
  task automatic send_msg(input logic [95:0] msg);
    send_word(msg[31:0]);
    idle_gap();
    send_word(msg[63:32]);
    idle_gap();
    send_word(msg[95:64]);
  endtask

  task automatic expect_report(input logic [31:0] expected, input logic running,
                               input string what, output int stamp);
    int waited;
    waited = 0;
    while (report_q.size() == 0) begin
      if (waited >= REPORT_TIMEOUT) begin
        stop_on_timeout(what);
      end
      step_cycle();
      check_value(app_error, 1'b0, "app_error stays low");
      waited++;
    end
    check_value(report_q.pop_front(), expected, what);
    check_value(report_running_q.pop_front(), running, {what, ", app_running"});
    stamp = report_cycle_q.pop_front();
  endtask

  task automatic after_reset_quiet();
    check_value(app_running, 1'b0, "app_running after reset");
    check_value(app_error, 1'b0, "app_error after reset");
    check_value(gpio_led, ST_STOPPED, "gpio_led after reset");
    repeat (QUIET_CYCLES) step_cycle();
    check_value(report_q.size(), 0, "no report while idle after reset");
  endtask

  task automatic three_frame_run();
    int stamp;
    frame_entry_cycles.delete();
    send_msg(control_msg(1'b1, 24'd3, 24'(RUN_CLOCKS)));
    expect_report(report_word(ST_STOPPED, ST_INIT, 24'd0), 1'b0, "stopped to init", stamp);
    expect_report(report_word(ST_INIT, ST_FRAME, 24'd0), 1'b1, "init to frame", stamp);
    frame_entry_cycles.push_back(stamp);
    for (int f = 1; f <= 2; f++) begin
      expect_report(report_word(ST_FRAME, ST_INTERFRAME, 24'(f)), 1'b1,
                    "frame to interframe", stamp);
      expect_report(report_word(ST_INTERFRAME, ST_FRAME, 24'(f)), 1'b1,
                    "interframe to frame", stamp);
      frame_entry_cycles.push_back(stamp);
    end
    expect_report(report_word(ST_FRAME, ST_STOPPED, 24'd3), 1'b0, "frame to stopped", stamp);
    check_value(gpio_led, ST_STOPPED, "gpio_led after the run");
  endtask

  task automatic frame_pacing();
    for (int i = 1; i < frame_entry_cycles.size(); i++) begin
      check_value(frame_entry_cycles[i] - frame_entry_cycles[i-1], RUN_CLOCKS,
                  "cycles between frame starts");
    end
  endtask

  task automatic early_stop();
    int stamp;
    send_msg(control_msg(1'b1, 24'd0, 24'(RUN_CLOCKS)));  // zero frames means run until stopped
    expect_report(report_word(ST_STOPPED, ST_INIT, 24'd0), 1'b0, "stopped to init", stamp);
    expect_report(report_word(ST_INIT, ST_FRAME, 24'd0), 1'b1, "init to frame", stamp);
    for (int f = 1; f <= 2; f++) begin
      expect_report(report_word(ST_FRAME, ST_INTERFRAME, 24'(f)), 1'b1,
                    "frame to interframe", stamp);
      expect_report(report_word(ST_INTERFRAME, ST_FRAME, 24'(f)), 1'b1,
                    "interframe to frame", stamp);
    end
    send_msg(control_msg(1'b0, 24'd0, 24'd0));
    // stop pulse is out but the state has not changed yet
    check_value(gpio_led, ST_FRAME, "third frame still running at stop");
    expect_report(report_word(ST_FRAME, ST_STOPPED, 24'd2), 1'b0,
                  "frame to stopped on stop", stamp);
    check_value(app_running, 1'b0, "app_running after stop");
  endtask

  task automatic ignored_messages();
    send_msg(data_msg());
    send_msg(control_msg(1'b0, 24'd0, 24'd0));  // stop while already stopped
    repeat (QUIET_CYCLES) step_cycle();
    check_value(report_q.size(), 0, "no report for ignored messages");
    check_value(gpio_led, ST_STOPPED, "gpio_led stays stopped");
  endtask

  initial begin
    RESET = 1'b1;
    pc_msg_valid = 1'b0;
    pc_msg = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    RESET = 1'b0;

    after_reset_quiet();
    three_frame_run();
    frame_pacing();
    early_stop();
    ignored_messages();

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/app_top.sv
`timescale 1ns/100ps
`default_nettype none

module app_top #(
  parameter int XB_SIZE = 32,
  parameter int N_ZMW = 128,            // power of two
  parameter int BRAM_READ_LATENCY = 3,  // at least 1
  localparam int ADDR_W = $clog2(N_ZMW)
) (
  input  wire                     CLK,
  input  wire                     RESET,
  input  wire                     pc_msg_valid,
  input  wire msg_pkg::xb_word_t  pc_msg,
  output logic                    pc_msg_ack,
  output logic                    fpga_msg_valid,
  output msg_pkg::xb_word_t       fpga_msg,
  output logic                    app_running,
  output logic                    app_error,
  output pacer_pkg::state_code_t  gpio_led
);

  logic start_pulse;
  logic stop_pulse;
  msg_pkg::frame_count_t n_frame;
  msg_pkg::clock_count_t clocks_per_frame;

  // bank ports
  logic rd_en0, rd_en1, wr_en0, wr_en1;
  logic rd_valid0, rd_valid1;
  logic [ADDR_W-1:0] addr0, addr1;
  pacer_pkg::entry_t rd_data0, rd_data1;
  pacer_pkg::entry_t wr_data;  // only one bank is written at a time

  pacer_pkg::pacer_state_e state;
  msg_pkg::frame_count_t frame_count;

  msg_assembler #(.XB_SIZE(XB_SIZE)) u_msg_assembler (
    .CLK(CLK), .RESET(RESET),
    .pc_msg_valid(pc_msg_valid), .pc_msg(pc_msg), .pc_msg_ack(pc_msg_ack),
    .start_pulse(start_pulse), .stop_pulse(stop_pulse),
    .n_frame(n_frame), .clocks_per_frame(clocks_per_frame)
  );

  pacer_fsm #(.N_ZMW(N_ZMW)) u_pacer_fsm (
    .CLK(CLK), .RESET(RESET),
    .start_pulse(start_pulse), .stop_pulse(stop_pulse),
    .n_frame(n_frame), .clocks_per_frame(clocks_per_frame),
    .rd_data0(rd_data0), .rd_data1(rd_data1),
    .rd_valid0(rd_valid0), .rd_valid1(rd_valid1),
    .rd_en0(rd_en0), .rd_en1(rd_en1), .wr_en0(wr_en0), .wr_en1(wr_en1),
    .addr0(addr0), .addr1(addr1), .wr_data(wr_data),
    .state(state), .frame_count(frame_count)
  );

  // bank 0 holds the identity list after INIT
  zmw_bank #(.N_ZMW(N_ZMW), .BRAM_READ_LATENCY(BRAM_READ_LATENCY)) u_bank0 (
    .CLK(CLK), .RESET(RESET),
    .rd_en(rd_en0), .wr_en(wr_en0), .addr(addr0), .wr_data(wr_data),
    .rd_data(rd_data0), .rd_valid(rd_valid0)
  );

  zmw_bank #(.N_ZMW(N_ZMW), .BRAM_READ_LATENCY(BRAM_READ_LATENCY)) u_bank1 (
    .CLK(CLK), .RESET(RESET),
    .rd_en(rd_en1), .wr_en(wr_en1), .addr(addr1), .wr_data(wr_data),
    .rd_data(rd_data1), .rd_valid(rd_valid1)
  );

  status_reporter u_status_reporter (
    .CLK(CLK), .RESET(RESET),
    .state(state), .frame_count(frame_count),
    .fpga_msg_valid(fpga_msg_valid), .fpga_msg(fpga_msg),
    .app_running(app_running), .app_error(app_error), .gpio_led(gpio_led)
  );

endmodule

`default_nettype wire

//--- hw/status_reporter.sv
`timescale 1ns/100ps
`default_nettype none

module status_reporter (
  input  wire                            CLK,
  input  wire                            RESET,
  input  wire pacer_pkg::pacer_state_e   state,
  input  wire msg_pkg::frame_count_t     frame_count,
  output logic                           fpga_msg_valid,
  output msg_pkg::xb_word_t              fpga_msg,
  output logic                           app_running,
  output logic                           app_error,
  output pacer_pkg::state_code_t         gpio_led
);

  pacer_pkg::pacer_state_e prev_state;
  logic changed;

  assign changed = state != prev_state;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      prev_state <= pacer_pkg::PACER_STOPPED;  // pacer comes out of reset here too
      fpga_msg_valid <= 1'b0;
    end else begin
      prev_state <= state;
      fpga_msg_valid <= changed;  // one word per change, host never stalls
    end
  end

  // report word: frame count, old code, new code
  always_ff @(posedge CLK) begin
    if (changed) begin
      fpga_msg <= {frame_count, pacer_pkg::state_code_t'(prev_state),
                   pacer_pkg::state_code_t'(state)};
    end
  end

  assign app_running = (state == pacer_pkg::PACER_FRAME)
                    || (state == pacer_pkg::PACER_INTERFRAME);
  assign app_error = state == pacer_pkg::PACER_ERROR;
  assign gpio_led = pacer_pkg::state_code_t'(state);  // raw state code

endmodule

`default_nettype wire

//--- pacer/pacer_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module pacer_fsm #(
  parameter int N_ZMW = 128,
  localparam int ADDR_W = $clog2(N_ZMW)
) (
  input  wire                          CLK,
  input  wire                          RESET,
  input  wire                          start_pulse,
  input  wire                          stop_pulse,
  input  wire msg_pkg::frame_count_t   n_frame,
  input  wire msg_pkg::clock_count_t   clocks_per_frame,
  input  wire pacer_pkg::entry_t       rd_data0,
  input  wire pacer_pkg::entry_t       rd_data1,
  input  wire                          rd_valid0,
  input  wire                          rd_valid1,
  output logic                         rd_en0,
  output logic                         rd_en1,
  output logic                         wr_en0,
  output logic                         wr_en1,
  output logic [ADDR_W-1:0]            addr0,
  output logic [ADDR_W-1:0]            addr1,
  output pacer_pkg::entry_t            wr_data,
  output pacer_pkg::pacer_state_e      state,
  output msg_pkg::frame_count_t        frame_count
);

  logic src_bank;              // bank read this frame, the other is written
  logic [ADDR_W-1:0] init_cnt;
  logic [ADDR_W:0] issue_cnt;  // msb set once all reads are out
  logic [ADDR_W-1:0] check_cnt;
  msg_pkg::clock_count_t frame_clk;  // 1 in the first FRAME cycle

  pacer_pkg::entry_t src_data;
  logic in_frame;
  logic issuing;
  logic src_valid;
  logic copy_ok;
  logic check_bad;
  logic last_check;
  logic last_frame;

  assign in_frame = state == pacer_pkg::PACER_FRAME;
  assign issuing = in_frame && !issue_cnt[ADDR_W];

  // returning data, late data after a stop is dropped
  assign src_valid = in_frame && (src_bank ? rd_valid1 : rd_valid0);
  assign src_data = src_bank ? rd_data1 : rd_data0;

  assign copy_ok = src_valid && (src_data == pacer_pkg::entry_t'(check_cnt));
  assign check_bad = src_valid && !copy_ok;
  assign last_check = copy_ok && (check_cnt == ADDR_W'(N_ZMW - 1));
  assign last_frame = (n_frame != '0) && (frame_count + 1'b1 == n_frame);

  // bank controls
  always_comb begin
    rd_en0 = issuing && !src_bank;
    rd_en1 = issuing && src_bank;
    wr_en0 = (state == pacer_pkg::PACER_INIT) || (copy_ok && src_bank);
    wr_en1 = copy_ok && !src_bank;
    addr0 = src_bank ? check_cnt : issue_cnt[ADDR_W-1:0];
    addr1 = src_bank ? issue_cnt[ADDR_W-1:0] : check_cnt;
    wr_data = src_data;  // copy to the other bank at the checked index
    if (state == pacer_pkg::PACER_INIT) begin
      addr0 = init_cnt;
      wr_data = pacer_pkg::entry_t'(init_cnt);  // identity list
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state <= pacer_pkg::PACER_STOPPED;
      frame_count <= '0;
      src_bank <= 1'b0;
      init_cnt <= '0;
      issue_cnt <= '0;
      check_cnt <= '0;
      frame_clk <= '0;
    end else begin
      frame_clk <= frame_clk + 1'b1;
      case (state)
        pacer_pkg::PACER_STOPPED: begin
          if (start_pulse) begin
            init_cnt <= '0;
            frame_count <= '0;
            src_bank <= 1'b0;  // first frame reads the list built in INIT
            state <= pacer_pkg::PACER_INIT;
          end
        end

        pacer_pkg::PACER_INIT: begin
          init_cnt <= init_cnt + 1'b1;
          if (stop_pulse) begin
            state <= pacer_pkg::PACER_STOPPED;
          end else if (init_cnt == ADDR_W'(N_ZMW - 1)) begin
            issue_cnt <= '0;
            check_cnt <= '0;
            frame_clk <= 24'd1;
            state <= pacer_pkg::PACER_FRAME;
          end
        end

        pacer_pkg::PACER_FRAME: begin
          if (issuing) begin
            issue_cnt <= issue_cnt + 1'b1;
          end
          if (copy_ok) begin
            check_cnt <= check_cnt + 1'b1;
          end
          if (check_bad) begin
            state <= pacer_pkg::PACER_ERROR;
          end else if (stop_pulse) begin
            state <= pacer_pkg::PACER_STOPPED;
          end else if (last_check) begin
            frame_count <= frame_count + 1'b1;
            src_bank <= !src_bank;  // banks swap roles
            state <= last_frame ? pacer_pkg::PACER_STOPPED : pacer_pkg::PACER_INTERFRAME;
          end
        end

        pacer_pkg::PACER_INTERFRAME: begin
          if (stop_pulse) begin
            state <= pacer_pkg::PACER_STOPPED;
          end else if (frame_clk >= clocks_per_frame) begin
            issue_cnt <= '0;
            check_cnt <= '0;
            frame_clk <= 24'd1;
            state <= pacer_pkg::PACER_FRAME;
          end
        end

        default: begin
          // error holds until reset
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- pacer/zmw_bank.sv
`timescale 1ns/100ps
`default_nettype none

module zmw_bank #(
  parameter int N_ZMW = 128,
  parameter int BRAM_READ_LATENCY = 3,
  localparam int ADDR_W = $clog2(N_ZMW)
) (
  input  wire                     CLK,
  input  wire                     RESET,
  input  wire                     rd_en,
  input  wire                     wr_en,
  input  wire [ADDR_W-1:0]        addr,
  input  wire pacer_pkg::entry_t  wr_data,
  output pacer_pkg::entry_t       rd_data,
  output logic                    rd_valid
);

  pacer_pkg::entry_t mem [N_ZMW];
  pacer_pkg::entry_t rd_pipe [BRAM_READ_LATENCY];  // stage 0 is the RAM output reg
  logic [BRAM_READ_LATENCY-1:0] vld_pipe;

  // single port, write and read share addr
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[addr] <= wr_data;
    end
    if (rd_en) begin
      rd_pipe[0] <= mem[addr];
    end
    for (int i = 1; i < BRAM_READ_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  // valid runs alongside the data stages
  always_ff @(posedge CLK) begin
    if (RESET) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= rd_en;
      for (int i = 1; i < BRAM_READ_LATENCY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  assign rd_data = rd_pipe[BRAM_READ_LATENCY-1];
  assign rd_valid = vld_pipe[BRAM_READ_LATENCY-1];

endmodule

`default_nettype wire

//--- hw/msg_assembler.sv
`timescale 1ns/100ps
`default_nettype none

module msg_assembler #(
  parameter int XB_SIZE = 32
) (
  input  wire                        CLK,
  input  wire                        RESET,
  input  wire                        pc_msg_valid,
  input  wire msg_pkg::xb_word_t     pc_msg,
  output logic                       pc_msg_ack,
  output logic                       start_pulse,
  output logic                       stop_pulse,
  output msg_pkg::frame_count_t      n_frame,
  output msg_pkg::clock_count_t      clocks_per_frame
);

  typedef enum logic [1:0] {WAIT1, WAIT2, WAIT3} asm_state_e;

  asm_state_e asm_state;
  logic [2*XB_SIZE-1:0] cache;  // words 1 and 2
  msg_pkg::whole_msg_t whole_msg;
  logic msg_done;
  logic is_control;

  assign pc_msg_ack = pc_msg_valid;  // every word taken at once

  // third word goes straight in, no extra cycle
  assign whole_msg = {pc_msg, cache};
  assign msg_done = pc_msg_valid && (asm_state == WAIT3);
  assign is_control = msg_done && !whole_msg[msg_pkg::MSG_TYPE_BIT];

  always_ff @(posedge CLK) begin
    if (RESET) begin
      asm_state <= WAIT1;
      start_pulse <= 1'b0;
      stop_pulse <= 1'b0;
    end else begin
      start_pulse <= is_control && whole_msg[msg_pkg::START_BIT];
      stop_pulse <= is_control && !whole_msg[msg_pkg::START_BIT];
      if (pc_msg_valid) begin
        case (asm_state)
          WAIT1: asm_state <= WAIT2;
          WAIT2: asm_state <= WAIT3;
          default: asm_state <= WAIT1;
        endcase
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (pc_msg_valid && asm_state == WAIT1) begin
      cache[0 +: XB_SIZE] <= pc_msg;
    end
    if (pc_msg_valid && asm_state == WAIT2) begin
      cache[XB_SIZE +: XB_SIZE] <= pc_msg;
    end
    // counts follow the last start message
    if (is_control && whole_msg[msg_pkg::START_BIT]) begin
      n_frame <= whole_msg[msg_pkg::N_FRAME_LSB +: msg_pkg::N_FRAME_WIDTH];
      clocks_per_frame <=
        whole_msg[msg_pkg::CLOCK_PER_FRAME_LSB +: msg_pkg::CLOCK_PER_FRAME_WIDTH];
    end
  end

endmodule

`default_nettype wire

//--- common/pacer_pkg.sv
`default_nettype none

// pacer state codes and pulse list bank data
package pacer_pkg;

  // raw state code as it leaves the chip in reports and on the LEDs
  typedef logic [3:0] state_code_t;

  // pacer FSM, codes are visible to the host
  typedef enum state_code_t {
    PACER_ERROR      = 4'd0,  // sticky, only reset leaves it
    PACER_STOPPED    = 4'd1,
    PACER_INIT       = 4'd2,  // filling bank 0 with the identity list
    PACER_FRAME      = 4'd3,  // reading, checking and copying one frame
    PACER_INTERFRAME = 4'd4   // waiting for the next frame start
  } pacer_state_e;

  // one pulse list entry
  // in this design it holds the entry index zero extended
  typedef logic [15:0] entry_t;

endpackage

`default_nettype wire

//--- common/msg_pkg.sv
`default_nettype none

// host message format shared by the input and output sides
package msg_pkg;

  // one word on the host bus
  typedef logic [31:0] xb_word_t;

  // three host words, first word received in bits 31:0
  typedef logic [95:0] whole_msg_t;

  // count fields of a control message
  typedef logic [23:0] frame_count_t;  // frames per run, 0 = until stopped
  typedef logic [23:0] clock_count_t;  // clocks from one frame start to the next

  // header bits
  localparam int MSG_TYPE_BIT = 0;  // 0 = control, 1 = data
  localparam int START_BIT = 6;     // control only, 1 = start, 0 = stop

  // control message fields
  localparam int N_FRAME_LSB = 8;
  localparam int N_FRAME_WIDTH = $bits(frame_count_t);

  localparam int CLOCK_PER_FRAME_LSB = 32;
  localparam int CLOCK_PER_FRAME_WIDTH = $bits(clock_count_t);

  // bits above the clock field hold stride and exposure, not decoded here

endpackage

`default_nettype wire
